/* decap_pkg.sv */
package decap_pkg;

    // Stream geometry
    localparam int BUS_BYTES = 8;
    localparam int DATA_WIDTH = 8 * BUS_BYTES;
    localparam int ID_WIDTH = 4;

    // Encapsulation modes and header sizes
    localparam int MODE_WIDTH = 3;
    localparam int SIZE_WIDTH = 6;

    // UDP over IPv4 over Ethernet
    localparam logic [MODE_WIDTH-1:0] UDP_MODE = 3'd5;
    // Source IP address starts here, pseudo-header begins
    localparam int CHECK_START = 26;
    localparam logic [15:0] UDP_PROTOCOL = 16'd17;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [BUS_BYTES-1:0]  keep;
        logic                  last;
        logic [ID_WIDTH-1:0]   dest;
    } axis_beat_t;

    // Error is only meaningful on the last beat
    typedef struct packed {
        logic [SIZE_WIDTH-1:0] size;
        logic                  check;
        logic                  error;
    } pkt_side_t;

    typedef struct packed {
        logic check;
        logic error;
    } out_side_t;

    function automatic logic [SIZE_WIDTH-1:0] encap_size(input logic [MODE_WIDTH-1:0] mode);
        case (mode)
            3'd0: encap_size = 6'd0;
            3'd1, 3'd2, 3'd3: encap_size = 6'd14;
            3'd4: encap_size = 6'd34;
            3'd5, 3'd6: encap_size = 6'd42;
            default: encap_size = 6'd50;
        endcase
    endfunction

endpackage

/* axis_reg_slice.sv */
`timescale 1ns/10ps

module axis_reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     reset,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t main_data;
    payload_t skid_data;
    logic     main_full;
    logic     skid_full;
    logic     in_fire;
    logic     main_free;

    assign in_fire = in_valid && in_ready;
    // Output register can take a new beat this cycle
    assign main_free = !main_full || out_ready;

    // Ready comes straight from a flop
    assign in_ready = !skid_full;
    assign out_valid = main_full;
    assign out_data = main_data;

    always_ff @(posedge aclk) begin
        if (reset) begin
            main_full <= 1'b0;
            skid_full <= 1'b0;
        end else if (main_free) begin
            main_full <= skid_full || in_fire;
            skid_full <= 1'b0;
        end else if (in_fire) begin
            skid_full <= 1'b1;
        end
    end

    // Skid entry drains first, input is blocked while it is full
    always_ff @(posedge aclk) begin
        if (main_free) begin
            main_data <= skid_full ? skid_data : in_data;
        end else if (in_fire) begin
            skid_data <= in_data;
        end
    end

endmodule

/* udp_checksum_check.sv */
`timescale 1ns/10ps

module udp_checksum_check (
    input  logic                             aclk,
    input  logic                             reset,
    input  decap_pkg::axis_beat_t            in_beat,
    input  logic                             in_has_udp_checksum,
    input  logic                             in_valid,
    output logic                             in_ready,
    output logic [decap_pkg::ID_WIDTH-1:0]   sel_id,
    input  logic [decap_pkg::MODE_WIDTH-1:0] encap_mode,
    output decap_pkg::axis_beat_t            out_beat,
    output decap_pkg::pkt_side_t             out_side,
    output logic                             out_valid,
    input  logic                             out_ready
);
    import decap_pkg::*;

    localparam int OFFSET_WIDTH = 16;
    // UDP length field, added once more for the pseudo-header
    localparam int LENGTH_OFFSET = 38;
    localparam int LENGTH_BEAT = (LENGTH_OFFSET / BUS_BYTES) * BUS_BYTES;
    localparam int LENGTH_WORD = (LENGTH_OFFSET % BUS_BYTES) / 2;

    logic [OFFSET_WIDTH-1:0] offset;
    logic [MODE_WIDTH-1:0]   mode_q;
    logic                    check_q;
    logic [16:0]             sum_q;

    logic                    head;
    logic                    fire;
    logic [MODE_WIDTH-1:0]   cur_mode;
    logic                    cur_check;
    logic [7:0]              masked [BUS_BYTES];
    logic [19:0]             beat_sum;
    logic [16:0]             sum_next;
    logic [15:0]             folded;

    assign head = (offset == '0);
    assign fire = in_valid && out_ready;
    assign sel_id = in_beat.dest;

    // Mode is only trusted on the head beat
    assign cur_mode = head ? encap_mode : mode_q;
    assign cur_check = head ? (encap_mode == UDP_MODE) && in_has_udp_checksum : check_q;

    always_comb begin
        for (int i = 0; i < BUS_BYTES; i++) begin
            if (in_beat.keep[i] && (int'(offset) + i >= CHECK_START)) begin
                masked[i] = in_beat.data[8*i +: 8];
            end else begin
                masked[i] = 8'h00;
            end
        end
    end

    // Big-endian words, a lone odd byte gets a zero low half
    always_comb begin
        beat_sum = head ? 20'(UDP_PROTOCOL) : 20'(sum_q);
        for (int w = 0; w < BUS_BYTES / 2; w++) begin
            beat_sum = beat_sum + 20'({masked[2*w], masked[2*w+1]});
        end
        if (offset == OFFSET_WIDTH'(LENGTH_BEAT)) begin
            beat_sum = beat_sum + 20'({masked[2*LENGTH_WORD], masked[2*LENGTH_WORD+1]});
        end
    end

    // End-around carry
    assign sum_next = 17'(beat_sum[15:0]) + 17'(beat_sum[19:16]);
    assign folded = sum_next[15:0] + 16'(sum_next[16]);

    assign out_beat = in_beat;
    assign out_valid = in_valid;
    assign in_ready = out_ready;

    assign out_side.size = encap_size(cur_mode);
    assign out_side.check = cur_check;
    assign out_side.error = cur_check && in_beat.last && (folded != 16'hFFFF);

    always_ff @(posedge aclk) begin
        if (reset) begin
            offset <= '0;
            mode_q <= '0;
            check_q <= 1'b0;
            sum_q <= '0;
        end else if (fire) begin
            offset <= in_beat.last ? '0 : offset + OFFSET_WIDTH'(BUS_BYTES);
            mode_q <= cur_mode;
            check_q <= cur_check;
            sum_q <= sum_next;
        end
    end

endmodule

/* header_stripper.sv */
`timescale 1ns/10ps

module header_stripper (
    input  logic                  aclk,
    input  logic                  reset,
    input  decap_pkg::axis_beat_t in_beat,
    input  decap_pkg::pkt_side_t  in_side,
    input  logic                  in_valid,
    output logic                  in_ready,
    output decap_pkg::axis_beat_t out_beat,
    output decap_pkg::out_side_t  out_side,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import decap_pkg::*;

    localparam int SHIFT_WIDTH = $clog2(BUS_BYTES);
    localparam int DROP_WIDTH = SIZE_WIDTH - SHIFT_WIDTH;

    // Input beat index within the packet, saturates past any drop count
    logic [DROP_WIDTH-1:0]  beat_cnt;
    logic                   flush;
    logic [SHIFT_WIDTH-1:0] shift_q;
    axis_beat_t             hold_beat;
    out_side_t              hold_side;

    logic [DROP_WIDTH-1:0]  drop_beats;
    logic [SHIFT_WIDTH-1:0] shift;
    logic                   dropping;
    logic                   at_first;
    logic                   merging;
    logic                   extra;
    logic                   in_fire;

    assign drop_beats = in_side.size[SIZE_WIDTH-1:SHIFT_WIDTH];
    assign shift = in_side.size[SHIFT_WIDTH-1:0];

    assign dropping = (beat_cnt < drop_beats);
    assign at_first = (beat_cnt == drop_beats);
    assign merging = (beat_cnt > drop_beats);

    // Last beat still has bytes past the shift point
    assign extra = in_beat.last && in_beat.keep[shift];

    assign in_ready = !flush && (!merging || out_ready);
    assign out_valid = flush || (in_valid && merging);
    assign in_fire = in_valid && in_ready;

    // Tail of the held beat low, head of the new beat on top
    always_comb begin
        out_beat.data = hold_beat.data >> (8 * shift_q);
        out_beat.keep = hold_beat.keep >> shift_q;
        out_beat.last = 1'b1;
        out_beat.dest = hold_beat.dest;
        out_side = hold_side;
        if (!flush) begin
            out_beat.data = out_beat.data | (in_beat.data << (8 * (BUS_BYTES - shift_q)));
            out_beat.keep = out_beat.keep | (in_beat.keep << (BUS_BYTES - shift_q));
            out_beat.last = in_beat.last && !in_beat.keep[shift_q];
            out_side.check = in_side.check;
            out_side.error = in_side.error;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            beat_cnt <= '0;
            flush <= 1'b0;
        end else begin
            if (in_fire) begin
                if (in_beat.last) begin
                    beat_cnt <= '0;
                end else if (beat_cnt != '1) begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
            if (flush && out_ready) begin
                flush <= 1'b0;
            end else if (in_fire && !dropping && extra) begin
                flush <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (in_fire && !dropping) begin
            hold_beat <= in_beat;
            hold_side <= '{check: in_side.check, error: in_side.error};
        end
        if (in_fire && at_first) begin
            shift_q <= shift;
        end
    end

endmodule

/* decapsulator.sv */
`timescale 1ns/10ps

module decapsulator (
    input  logic                             aclk,
    input  logic                             reset,
    input  decap_pkg::axis_beat_t            in_beat,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic                             in_has_udp_checksum,
    output logic [decap_pkg::ID_WIDTH-1:0]   sel_id,
    input  logic [decap_pkg::MODE_WIDTH-1:0] encap_mode,
    output decap_pkg::axis_beat_t            out_beat,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic                             poisoned,
    output logic                             parsing_done
);
    import decap_pkg::*;

    typedef struct packed {
        axis_beat_t beat;
        logic       has_udp_checksum;
    } in_slot_t;

    typedef struct packed {
        axis_beat_t beat;
        out_side_t  side;
    } out_slot_t;

    in_slot_t   in_slot;
    in_slot_t   chk_slot;
    logic       chk_valid;
    logic       chk_ready;

    axis_beat_t strip_in_beat;
    pkt_side_t  strip_in_side;
    logic       strip_in_valid;
    logic       strip_in_ready;

    out_slot_t  strip_slot;
    logic       strip_valid;
    logic       strip_ready;
    out_slot_t  out_slot;

    assign in_slot.beat = in_beat;
    assign in_slot.has_udp_checksum = in_has_udp_checksum;

    axis_reg_slice #(
        .payload_t (in_slot_t)
    ) in_slice (
        .aclk      (aclk),
        .reset     (reset),
        .in_data   (in_slot),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (chk_slot),
        .out_valid (chk_valid),
        .out_ready (chk_ready)
    );

    udp_checksum_check i_checksum (
        .aclk                (aclk),
        .reset               (reset),
        .in_beat             (chk_slot.beat),
        .in_has_udp_checksum (chk_slot.has_udp_checksum),
        .in_valid            (chk_valid),
        .in_ready            (chk_ready),
        .sel_id              (sel_id),
        .encap_mode          (encap_mode),
        .out_beat            (strip_in_beat),
        .out_side            (strip_in_side),
        .out_valid           (strip_in_valid),
        .out_ready           (strip_in_ready)
    );

    header_stripper i_stripper (
        .aclk      (aclk),
        .reset     (reset),
        .in_beat   (strip_in_beat),
        .in_side   (strip_in_side),
        .in_valid  (strip_in_valid),
        .in_ready  (strip_in_ready),
        .out_beat  (strip_slot.beat),
        .out_side  (strip_slot.side),
        .out_valid (strip_valid),
        .out_ready (strip_ready)
    );

    axis_reg_slice #(
        .payload_t (out_slot_t)
    ) out_slice (
        .aclk      (aclk),
        .reset     (reset),
        .in_data   (strip_slot),
        .in_valid  (strip_valid),
        .in_ready  (strip_ready),
        .out_data  (out_slot),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    assign out_beat = out_slot.beat;

    // Flags only count on the last beat
    assign poisoned = out_slot.side.error && out_slot.beat.last;
    assign parsing_done = !out_slot.side.check || out_slot.beat.last;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic aclk,
    output logic reset
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // Released on a rising edge, seen by the DUT one edge later
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        reset <= 1'b0;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/10ps

module tb_checker (
    input  logic                  aclk,
    input  decap_pkg::axis_beat_t out_beat,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  logic                  poisoned,
    input  logic                  parsing_done,
    output int                    tests_done,
    output int                    tests_failed,
    output int                    error_count
);
    import decap_pkg::*;

    typedef struct packed {
        axis_beat_t beat;
        logic       poisoned;
        logic       parsing_done;
    } exp_beat_t;

    exp_beat_t exp_q[$];
    string     label_q[$];
    int        n_done = 0;
    int        n_failed = 0;
    int        n_errors = 0;
    int        pkt_errors = 0;

    assign tests_done = n_done;
    assign tests_failed = n_failed;
    assign error_count = n_errors;

    function automatic void expect_beat(input axis_beat_t beat, input logic poison,
                                        input logic done);
        exp_beat_t e;
        e.beat = beat;
        e.poisoned = poison;
        e.parsing_done = done;
        exp_q.push_back(e);
    endfunction

    function automatic void expect_label(input string label);
        label_q.push_back(label);
    endfunction

    task automatic check_field(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0d ns: %s is %0h, expected %0h", $time, name, got, want);
            n_errors++;
            pkt_errors++;
        end
    endtask

    task automatic close_test();
        string label;
        label = "unlabeled packet";
        if (label_q.size() != 0) begin
            label = label_q.pop_front();
        end
        n_done++;
        if (pkt_errors == 0) begin
            $display("PASS  %s", label);
        end else begin
            n_failed++;
            $display("FAIL  %s, %0d mismatches", label, pkt_errors);
        end
        pkt_errors = 0;
    endtask

    // Mid-cycle, valid, ready and data are all settled
    always @(negedge aclk) begin : compare_beat
        exp_beat_t             want;
        logic [DATA_WIDTH-1:0] mask;
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output beat at %0d ns arrived with no packet pending", $time);
                n_errors++;
            end else begin
                want = exp_q.pop_front();
                for (int i = 0; i < BUS_BYTES; i++) begin
                    mask[8*i +: 8] = {8{want.beat.keep[i]}};
                end
                check_field("out_beat.data", out_beat.data & mask, want.beat.data);
                check_field("out_beat.keep", DATA_WIDTH'(out_beat.keep), DATA_WIDTH'(want.beat.keep));
                check_field("out_beat.last", DATA_WIDTH'(out_beat.last), DATA_WIDTH'(want.beat.last));
                check_field("out_beat.dest", DATA_WIDTH'(out_beat.dest), DATA_WIDTH'(want.beat.dest));
                check_field("poisoned", DATA_WIDTH'(poisoned), DATA_WIDTH'(want.poisoned));
                check_field("parsing_done", DATA_WIDTH'(parsing_done),
                            DATA_WIDTH'(want.parsing_done));
                if (want.beat.last) begin
                    close_test();
                end
            end
        end
    end

endmodule

/* tb_decapsulator.sv */
`timescale 1ns/10ps

module tb_decapsulator;
    import decap_pkg::*;

    localparam int NUM_PACKETS = 48;
    localparam int MAX_BYTES = 96;

    logic                  aclk;
    logic                  reset;
    axis_beat_t            in_beat;
    logic                  in_valid;
    logic                  in_ready;
    logic                  in_has_udp_checksum;
    logic [ID_WIDTH-1:0]   sel_id;
    logic [MODE_WIDTH-1:0] encap_mode;
    axis_beat_t            out_beat;
    logic                  out_valid;
    logic                  out_ready;
    logic                  poisoned;
    logic                  parsing_done;
    int                    tests_done;
    int                    tests_failed;
    int                    error_count;

    logic [31:0]   rng_state = 32'd70930;
    logic [7:0]    pkt_bytes [NUM_PACKETS][MAX_BYTES];
    int            pkt_len [NUM_PACKETS];
    logic [3:0]    pkt_dest [NUM_PACKETS];
    logic          pkt_flag [NUM_PACKETS];
    int            total_beats = 0;
    int            cycle_limit = 0;

    tb_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (5)
    ) i_clock (
        .aclk  (aclk),
        .reset (reset)
    );

    decapsulator i_dut (
        .aclk                (aclk),
        .reset               (reset),
        .in_beat             (in_beat),
        .in_valid            (in_valid),
        .in_ready            (in_ready),
        .in_has_udp_checksum (in_has_udp_checksum),
        .sel_id              (sel_id),
        .encap_mode          (encap_mode),
        .out_beat            (out_beat),
        .out_valid           (out_valid),
        .out_ready           (out_ready),
        .poisoned            (poisoned),
        .parsing_done        (parsing_done)
    );

    tb_checker i_checker (
        .aclk         (aclk),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .poisoned     (poisoned),
        .parsing_done (parsing_done),
        .tests_done   (tests_done),
        .tests_failed (tests_failed),
        .error_count  (error_count)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Config table mapping dest id to encapsulation mode
    function automatic logic [MODE_WIDTH-1:0] lookup_mode(input logic [ID_WIDTH-1:0] id);
        case (id)
            4'd0, 4'd9: return 3'd0;
            4'd1, 4'd10: return 3'd1;
            4'd2, 4'd11: return 3'd2;
            4'd3, 4'd12: return 3'd3;
            4'd4, 4'd13: return 3'd4;
            4'd5, 4'd8, 4'd14: return 3'd5;
            4'd6: return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    assign encap_mode = lookup_mode(sel_id);

    function automatic int header_bytes(input logic [MODE_WIDTH-1:0] mode);
        case (mode)
            3'd0: return 0;
            3'd1, 3'd2, 3'd3: return 14;
            3'd4: return 34;
            3'd5, 3'd6: return 42;
            default: return 50;
        endcase
    endfunction

    // One's-complement sum over pseudo-header, UDP header and payload
    function automatic logic [15:0] udp_sum(input int p);
        logic [31:0] acc;
        logic [7:0]  low;
        acc = 32'(UDP_PROTOCOL) + {16'h0, pkt_bytes[p][38], pkt_bytes[p][39]};
        for (int i = CHECK_START; i < pkt_len[p]; i += 2) begin
            low = (i + 1 < pkt_len[p]) ? pkt_bytes[p][i+1] : 8'h00;
            acc += {16'h0, pkt_bytes[p][i], low};
        end
        while (acc[31:16] != 16'h0) begin
            acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        end
        return acc[15:0];
    endfunction

    function automatic void queue_expected(input int p);
        logic [MODE_WIDTH-1:0] mode;
        int                    hdr;
        int                    nbytes;
        logic                  check;
        logic                  poison;
        axis_beat_t            beat;
        mode = lookup_mode(pkt_dest[p]);
        hdr = header_bytes(mode);
        nbytes = pkt_len[p] - hdr;
        check = (mode == 3'd5) && pkt_flag[p];
        poison = check && (udp_sum(p) != 16'hFFFF);
        for (int b = 0; b < nbytes; b += BUS_BYTES) begin
            beat = '0;
            beat.dest = pkt_dest[p];
            beat.last = (b + BUS_BYTES >= nbytes);
            for (int i = 0; i < BUS_BYTES && b + i < nbytes; i++) begin
                beat.data[8*i +: 8] = pkt_bytes[p][hdr + b + i];
                beat.keep[i] = 1'b1;
            end
            i_checker.expect_beat(beat, poison && beat.last, !check || beat.last);
        end
        i_checker.expect_label($sformatf("packet %0d mode %0d flag %0d, %0d bytes out",
                                         p, mode, pkt_flag[p], nbytes));
    endfunction

    // Rounds of 16 with a good checksum, then corrupted, then corrupted with the flag clear
    task automatic build_packets();
        int          hdr;
        logic [15:0] csum;
        for (int p = 0; p < NUM_PACKETS; p++) begin
            pkt_dest[p] = 4'(p % 16);
            pkt_flag[p] = (p / 16) != 2;
            hdr = header_bytes(lookup_mode(pkt_dest[p]));
            pkt_len[p] = hdr + int'(next_rand() % 40) + 1;
            for (int i = 0; i < pkt_len[p]; i++) begin
                pkt_bytes[p][i] = 8'(next_rand());
            end
            if (hdr >= 42) begin
                {pkt_bytes[p][38], pkt_bytes[p][39]} = 16'(pkt_len[p] - 34);
                {pkt_bytes[p][40], pkt_bytes[p][41]} = 16'h0000;
                csum = ~udp_sum(p);
                if (p / 16 != 0) begin
                    csum ^= 16'h0001;
                end
                {pkt_bytes[p][40], pkt_bytes[p][41]} = csum;
            end
            total_beats += (pkt_len[p] + BUS_BYTES - 1) / BUS_BYTES;
            queue_expected(p);
        end
        cycle_limit = 20 * total_beats + 200;
    endtask

    task automatic wait_for_reset();
        @(negedge aclk);
        while (reset !== 1'b0) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
    endtask

    task automatic send_packet(input int p);
        int         nbeats;
        axis_beat_t beat;
        nbeats = (pkt_len[p] + BUS_BYTES - 1) / BUS_BYTES;
        for (int b = 0; b < nbeats; b++) begin
            beat = '0;
            beat.dest = pkt_dest[p];
            beat.last = (b == nbeats - 1);
            for (int i = 0; i < BUS_BYTES && 8*b + i < pkt_len[p]; i++) begin
                beat.data[8*i +: 8] = pkt_bytes[p][8*b + i];
                beat.keep[i] = 1'b1;
            end
            in_beat = beat;
            in_has_udp_checksum = pkt_flag[p];
            in_valid = 1'b1;
            // in_ready only moves on an edge, so its value now holds for the next one
            while (!in_ready) begin
                @(posedge aclk);
                #1;
            end
            @(posedge aclk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    initial begin
        in_beat = '0;
        in_valid = 1'b0;
        in_has_udp_checksum = 1'b0;
        build_packets();
        wait_for_reset();
        for (int p = 0; p < NUM_PACKETS; p++) begin
            send_packet(p);
        end
        wait (tests_done == NUM_PACKETS);
        // Catch any stray beats after the last packet
        repeat (10) @(posedge aclk);
        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_done, tests_done - tests_failed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Sink stalls about a quarter of the cycles
    initial begin
        out_ready = 1'b0;
        wait_for_reset();
        forever begin
            out_ready = (next_rand() % 4) != 0;
            @(posedge aclk);
            #1;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: %0d cycles passed and not all packets came out", cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* filelist.f */
decap_pkg.sv
axis_reg_slice.sv
udp_checksum_check.sv
header_stripper.sv
decapsulator.sv
tb_clock_gen.sv
tb_checker.sv
tb_decapsulator.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_decapsulator \
        -f filelist.f -o sim_decap; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/sim_decap); then
    echo "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi
echo "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
